/* rtl/axi_wb_cfg.svh */
`ifndef AXI_WB_CFG_SVH
`define AXI_WB_CFG_SVH

// AXI4-Lite side widths
`define AXI_ADDR_W   10
`define AXI_DATA_W   32

// Wishbone side widths, word address taken from AXI byte address bits 8 down to 2
`define WB_DATA_W    8
`define WB_ADR_W     7

// Register peripheral layout and timing
`define REG_COUNT    16
`define WB_ACK_DELAY 2
`define WB_TIMEOUT   16

`endif

/* rtl/axi_wb_pkg.sv */
package axi_wb_pkg;

    // Direction of one bridged transfer
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    // AXI response codes, EXOKAY is never produced
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    // Wishbone cycle controller states
    typedef enum logic [1:0] {
        WB_IDLE   = 2'd0,
        WB_ACTIVE = 2'd1,
        WB_DONE   = 2'd2
    } wb_state_e;

endpackage

/* rtl/axi_lite_slave.sv */
`timescale 1ns/1ps
`include "axi_wb_cfg.svh"

module axi_lite_slave (
    input  logic                       S_AXI_ACLK,
    input  logic                       S_AXI_ARESETN,
    // Write address and write data channels
    input  logic [`AXI_ADDR_W-1:0]     s_axi_awaddr_i,
    input  logic                       s_axi_awvalid_i,
    output logic                       s_axi_awready_o,
    input  logic [`AXI_DATA_W-1:0]     s_axi_wdata_i,
    input  logic [`AXI_DATA_W/8-1:0]   s_axi_wstrb_i,
    input  logic                       s_axi_wvalid_i,
    output logic                       s_axi_wready_o,
    // Write response channel
    output logic [1:0]                 s_axi_bresp_o,
    output logic                       s_axi_bvalid_o,
    input  logic                       s_axi_bready_i,
    // Read address and read data channels
    input  logic [`AXI_ADDR_W-1:0]     s_axi_araddr_i,
    input  logic                       s_axi_arvalid_i,
    output logic                       s_axi_arready_o,
    output logic [`AXI_DATA_W-1:0]     s_axi_rdata_o,
    output logic [1:0]                 s_axi_rresp_o,
    output logic                       s_axi_rvalid_o,
    input  logic                       s_axi_rready_i,
    // Towards the Wishbone cycle controller
    input  logic                       cyc_busy_i,
    input  logic                       cyc_done_i,
    input  axi_wb_pkg::axi_resp_e      cyc_resp_i,
    input  logic [`WB_DATA_W-1:0]      cyc_rdat_i,
    output logic                       cyc_start_o,
    output axi_wb_pkg::bus_op_e        cyc_op_o,
    output logic [`WB_ADR_W-1:0]       cyc_adr_o,
    output logic [`WB_DATA_W-1:0]      cyc_wdat_o,
    output logic                       cyc_sel_o,
    output logic                       busy_o
);
    import axi_wb_pkg::*;

    // One transaction in flight, from the ready pulse until its response is taken
    logic                   pending;
    logic                   aw_rdy;
    logic                   ar_rdy;
    // Start request waiting for the controller to be idle
    logic                   req_q;
    // Latched request payload
    bus_op_e                op_q;
    logic [`WB_ADR_W-1:0]   adr_q;
    logic [`WB_DATA_W-1:0]  wdat_q;
    logic                   sel_q;
    // Channel handshakes
    logic                   wr_hs;
    logic                   rd_hs;
    logic                   b_hs;
    logic                   r_hs;

    assign wr_hs = aw_rdy && s_axi_awvalid_i && s_axi_wvalid_i;
    assign rd_hs = ar_rdy && s_axi_arvalid_i;
    assign b_hs  = s_axi_bvalid_o && s_axi_bready_i;
    assign r_hs  = s_axi_rvalid_o && s_axi_rready_i;

    // AW and W are always accepted together
    assign s_axi_awready_o = aw_rdy;
    assign s_axi_wready_o  = aw_rdy;
    assign s_axi_arready_o = ar_rdy;
    assign busy_o          = pending;

    // Acceptance, write wins when both channels request in the same cycle
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            pending <= 1'b0;
            aw_rdy  <= 1'b0;
            ar_rdy  <= 1'b0;
        end
        else
        begin
            // Ready is a single-cycle pulse
            aw_rdy <= 1'b0;
            ar_rdy <= 1'b0;
            if (!pending)
            begin
                if (s_axi_awvalid_i && s_axi_wvalid_i)
                begin
                    aw_rdy  <= 1'b1;
                    pending <= 1'b1;
                end
                else if (s_axi_arvalid_i)
                begin
                    ar_rdy  <= 1'b1;
                    pending <= 1'b1;
                end
            end
            // Free again once the master has taken the response
            else if (b_hs || r_hs)
            begin
                pending <= 1'b0;
            end
        end
    end

    // Capture address, low data byte and strobe bit at the handshake
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (wr_hs)
        begin
            op_q   <= OP_WRITE;
            adr_q  <= s_axi_awaddr_i[`WB_ADR_W+1:2];
            wdat_q <= s_axi_wdata_i[`WB_DATA_W-1:0];
            sel_q  <= s_axi_wstrb_i[0];
        end
        else if (rd_hs)
        begin
            op_q  <= OP_READ;
            adr_q <= s_axi_araddr_i[`WB_ADR_W+1:2];
            // Reads always select the single byte lane
            sel_q <= 1'b1;
        end
    end

    // Hold the request until the controller is idle
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            req_q <= 1'b0;
        end
        else if (wr_hs || rd_hs)
        begin
            req_q <= 1'b1;
        end
        else if (!cyc_busy_i)
        begin
            req_q <= 1'b0;
        end
    end

    assign cyc_start_o = req_q && !cyc_busy_i;
    assign cyc_op_o    = op_q;
    assign cyc_adr_o   = adr_q;
    assign cyc_wdat_o  = wdat_q;
    assign cyc_sel_o   = sel_q;

    // Response registers, held steady until accepted
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            s_axi_bvalid_o <= 1'b0;
            s_axi_bresp_o  <= RESP_OKAY;
            s_axi_rvalid_o <= 1'b0;
            s_axi_rresp_o  <= RESP_OKAY;
            s_axi_rdata_o  <= '0;
        end
        else
        begin
            if (b_hs)
                s_axi_bvalid_o <= 1'b0;
            if (r_hs)
                s_axi_rvalid_o <= 1'b0;
            // Route the finished cycle to the matching channel
            if (cyc_done_i && op_q == OP_WRITE)
            begin
                s_axi_bvalid_o <= 1'b1;
                s_axi_bresp_o  <= cyc_resp_i;
            end
            else if (cyc_done_i)
            begin
                s_axi_rvalid_o <= 1'b1;
                s_axi_rresp_o  <= cyc_resp_i;
                // Byte zero-extended, nothing returned on an error
                if (cyc_resp_i == RESP_OKAY)
                    s_axi_rdata_o <= {{(`AXI_DATA_W-`WB_DATA_W){1'b0}}, cyc_rdat_i};
                else
                    s_axi_rdata_o <= '0;
            end
        end
    end

endmodule

/* rtl/wb_cycle.sv */
`timescale 1ns/1ps
`include "axi_wb_cfg.svh"

module wb_cycle (
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,
    // Request from the AXI front end
    input  logic                    start_i,
    input  axi_wb_pkg::bus_op_e     op_i,
    input  logic [`WB_ADR_W-1:0]    adr_i,
    input  logic [`WB_DATA_W-1:0]   wdat_i,
    input  logic                    sel_i,
    output logic                    busy_o,
    output logic                    done_o,
    output axi_wb_pkg::axi_resp_e   resp_o,
    output logic [`WB_DATA_W-1:0]   rdat_o,
    // Classic Wishbone master
    input  logic                    wb_ack_i,
    input  logic                    wb_err_i,
    input  logic [`WB_DATA_W-1:0]   wb_dat_i,
    output logic                    wb_cyc_o,
    output logic                    wb_stb_o,
    output logic                    wb_we_o,
    output logic [`WB_ADR_W-1:0]    wb_adr_o,
    output logic [`WB_DATA_W-1:0]   wb_dat_o,
    output logic                    wb_sel_o
);
    import axi_wb_pkg::*;

    localparam int TMO_W = $clog2(`WB_TIMEOUT);

    wb_state_e          state;
    // Cycles spent with the strobe up and no answer
    logic [TMO_W-1:0]   wait_cnt;
    logic               expired;

    assign expired = (wait_cnt == TMO_W'(`WB_TIMEOUT - 1));
    assign busy_o  = (state != WB_IDLE);
    // One-cycle finish pulse, the cycle after the bus answered
    assign done_o  = (state == WB_DONE);

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            state    <= WB_IDLE;
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            wait_cnt <= '0;
            resp_o   <= RESP_OKAY;
            rdat_o   <= '0;
        end
        else
        begin
            case (state)
                WB_IDLE:
                begin
                    if (start_i)
                    begin
                        state    <= WB_ACTIVE;
                        wb_cyc_o <= 1'b1;
                        wb_stb_o <= 1'b1;
                        wait_cnt <= '0;
                    end
                end
                WB_ACTIVE:
                begin
                    // Acknowledge has priority over error
                    if (wb_ack_i)
                    begin
                        resp_o <= RESP_OKAY;
                        rdat_o <= wb_dat_i;
                    end
                    else if (wb_err_i)
                        resp_o <= RESP_SLVERR;
                    else if (expired)
                        resp_o <= RESP_DECERR;
                    // Any of the three ends the bus cycle
                    if (wb_ack_i || wb_err_i || expired)
                    begin
                        state    <= WB_DONE;
                        wb_cyc_o <= 1'b0;
                        wb_stb_o <= 1'b0;
                    end
                    else
                        wait_cnt <= wait_cnt + 1'b1;
                end
                WB_DONE:
                    state <= WB_IDLE;
                default:
                    state <= WB_IDLE;
            endcase
        end
    end

    // Bus payload is loaded once per cycle
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (state == WB_IDLE && start_i)
        begin
            wb_we_o  <= (op_i == OP_WRITE);
            wb_adr_o <= adr_i;
            wb_dat_o <= wdat_i;
            wb_sel_o <= sel_i;
        end
    end

endmodule

/* rtl/wb_reg_file.sv */
`timescale 1ns/1ps
`include "axi_wb_cfg.svh"

module wb_reg_file (
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,
    // Classic Wishbone slave
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  logic [`WB_ADR_W-1:0]    wb_adr_i,
    input  logic [`WB_DATA_W-1:0]   wb_dat_i,
    input  logic                    wb_sel_i,
    output logic                    wb_ack_o,
    output logic                    wb_err_o,
    output logic [`WB_DATA_W-1:0]   wb_dat_o
);
    localparam int IDX_W = $clog2(`REG_COUNT);
    localparam int DLY_W = $clog2(`WB_ACK_DELAY + 1);

    logic [`WB_DATA_W-1:0]  regs [`REG_COUNT];
    // Wait states since the strobe was first seen
    logic [DLY_W-1:0]       wait_cnt;
    logic                   strobe;
    logic                   answer;
    logic                   in_reg;
    logic                   in_err;
    logic [IDX_W-1:0]       idx;

    // Strobe still waiting for its answer
    assign strobe = wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o;
    assign answer = strobe && (wait_cnt == DLY_W'(`WB_ACK_DELAY - 1));
    // Register window, then an equally sized error window, silence above
    assign in_reg = (int'(wb_adr_i) < `REG_COUNT);
    assign in_err = !in_reg && (int'(wb_adr_i) < 2 * `REG_COUNT);
    assign idx    = wb_adr_i[IDX_W-1:0];

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
            wb_dat_o <= '0;
            wait_cnt <= '0;
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else
        begin
            // ack and err are single-cycle pulses
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
            if (!strobe)
                wait_cnt <= '0;
            else if (answer)
            begin
                wait_cnt <= '0;
                if (in_reg)
                begin
                    wb_ack_o <= 1'b1;
                    wb_dat_o <= regs[idx];
                    // Byte lane must be selected for the write to land
                    if (wb_we_i && wb_sel_i)
                        regs[idx] <= wb_dat_i;
                end
                else if (in_err)
                    wb_err_o <= 1'b1;
            end
            else
                wait_cnt <= wait_cnt + 1'b1;
        end
    end

endmodule

/* rtl/axi_wb_bridge_top.sv */
`timescale 1ns/1ps
`include "axi_wb_cfg.svh"

module axi_wb_bridge_top (
    input  logic                       S_AXI_ACLK,
    input  logic                       S_AXI_ARESETN,
    input  logic [`AXI_ADDR_W-1:0]     s_axi_awaddr_i,
    input  logic                       s_axi_awvalid_i,
    output logic                       s_axi_awready_o,
    input  logic [`AXI_DATA_W-1:0]     s_axi_wdata_i,
    input  logic [`AXI_DATA_W/8-1:0]   s_axi_wstrb_i,
    input  logic                       s_axi_wvalid_i,
    output logic                       s_axi_wready_o,
    output logic [1:0]                 s_axi_bresp_o,
    output logic                       s_axi_bvalid_o,
    input  logic                       s_axi_bready_i,
    input  logic [`AXI_ADDR_W-1:0]     s_axi_araddr_i,
    input  logic                       s_axi_arvalid_i,
    output logic                       s_axi_arready_o,
    output logic [`AXI_DATA_W-1:0]     s_axi_rdata_o,
    output logic [1:0]                 s_axi_rresp_o,
    output logic                       s_axi_rvalid_o,
    input  logic                       s_axi_rready_i,
    output logic                       busy_o
);
    import axi_wb_pkg::*;

    // Front end to cycle controller
    logic                   cyc_start;
    bus_op_e                cyc_op;
    logic [`WB_ADR_W-1:0]   cyc_adr;
    logic [`WB_DATA_W-1:0]  cyc_wdat;
    logic                   cyc_sel;
    logic                   cyc_busy;
    logic                   cyc_done;
    axi_resp_e              cyc_resp;
    logic [`WB_DATA_W-1:0]  cyc_rdat;
    // Wishbone bus between controller and peripheral
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`WB_ADR_W-1:0]   wb_adr;
    logic [`WB_DATA_W-1:0]  wb_wdat;
    logic                   wb_sel;
    logic                   wb_ack;
    logic                   wb_err;
    logic [`WB_DATA_W-1:0]  wb_rdat;

    axi_lite_slave u_axi (
        .S_AXI_ACLK      (S_AXI_ACLK),
        .S_AXI_ARESETN   (S_AXI_ARESETN),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wstrb_i   (s_axi_wstrb_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i),
        .cyc_busy_i      (cyc_busy),
        .cyc_done_i      (cyc_done),
        .cyc_resp_i      (cyc_resp),
        .cyc_rdat_i      (cyc_rdat),
        .cyc_start_o     (cyc_start),
        .cyc_op_o        (cyc_op),
        .cyc_adr_o       (cyc_adr),
        .cyc_wdat_o      (cyc_wdat),
        .cyc_sel_o       (cyc_sel),
        .busy_o          (busy_o)
    );

    wb_cycle u_cyc (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .start_i       (cyc_start),
        .op_i          (cyc_op),
        .adr_i         (cyc_adr),
        .wdat_i        (cyc_wdat),
        .sel_i         (cyc_sel),
        .busy_o        (cyc_busy),
        .done_o        (cyc_done),
        .resp_o        (cyc_resp),
        .rdat_o        (cyc_rdat),
        .wb_ack_i      (wb_ack),
        .wb_err_i      (wb_err),
        .wb_dat_i      (wb_rdat),
        .wb_cyc_o      (wb_cyc),
        .wb_stb_o      (wb_stb),
        .wb_we_o       (wb_we),
        .wb_adr_o      (wb_adr),
        .wb_dat_o      (wb_wdat),
        .wb_sel_o      (wb_sel)
    );

    wb_reg_file u_regs (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wb_cyc_i      (wb_cyc),
        .wb_stb_i      (wb_stb),
        .wb_we_i       (wb_we),
        .wb_adr_i      (wb_adr),
        .wb_dat_i      (wb_wdat),
        .wb_sel_i      (wb_sel),
        .wb_ack_o      (wb_ack),
        .wb_err_o      (wb_err),
        .wb_dat_o      (wb_rdat)
    );

endmodule

/* verif/axi_wb_checker.sv */
`timescale 1ns/1ps
`include "axi_wb_cfg.svh"

module axi_wb_checker (
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,
    input  logic                    awvalid_i,
    input  logic                    awready_i,
    input  logic                    bvalid_i,
    input  logic                    bready_i,
    input  logic [1:0]              bresp_i,
    input  logic                    rvalid_i,
    input  logic                    rready_i,
    input  logic [1:0]              rresp_i,
    input  logic [`AXI_DATA_W-1:0]  rdata_i,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    busy_i
);
    // Failure count, read by the testbench at the end of the run
    int fail_cnt = 0;

    // Write response held until the master takes it
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (bvalid_i && !bready_i) |=> (bvalid_i && $stable(bresp_i)))
    else
    begin
        $error("write response dropped or changed before BREADY");
        fail_cnt++;
    end

    // Read response and data held until the master takes them
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (rvalid_i && !rready_i) |=> (rvalid_i && $stable(rresp_i) && $stable(rdata_i)))
    else
    begin
        $error("read response dropped or changed before RREADY");
        fail_cnt++;
    end

    // Strobe only inside a bus cycle
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        wb_stb_i |-> wb_cyc_i)
    else
    begin
        $error("Wishbone strobe without cycle");
        fail_cnt++;
    end

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        wb_cyc_i |-> busy_i)
    else
    begin
        $error("Wishbone cycle while bridge reports idle");
        fail_cnt++;
    end

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        awready_i |-> awvalid_i)
    else
    begin
        $error("AWREADY raised without AWVALID");
        fail_cnt++;
    end

endmodule

bind axi_wb_bridge_top axi_wb_checker u_checker (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awvalid_i     (s_axi_awvalid_i),
    .awready_i     (s_axi_awready_o),
    .bvalid_i      (s_axi_bvalid_o),
    .bready_i      (s_axi_bready_i),
    .bresp_i       (s_axi_bresp_o),
    .rvalid_i      (s_axi_rvalid_o),
    .rready_i      (s_axi_rready_i),
    .rresp_i       (s_axi_rresp_o),
    .rdata_i       (s_axi_rdata_o),
    .wb_cyc_i      (wb_cyc),
    .wb_stb_i      (wb_stb),
    .busy_i        (busy_o)
);

/* verif/tb_axi_wb_bridge.sv */
`timescale 1ns/1ps
`include "axi_wb_cfg.svh"

module tb_axi_wb_bridge;

    typedef struct {
        byte                    op;
        logic [`AXI_ADDR_W-1:0] awaddr;
        logic [`AXI_DATA_W-1:0] wdata;
        logic [3:0]             wstrb;
        logic [`AXI_ADDR_W-1:0] araddr;
        logic [`AXI_DATA_W-1:0] rdata;
        logic [1:0]             bresp;
        logic [1:0]             rresp;
    } stim_t;

    logic                       S_AXI_ACLK = 1'b0;
    logic                       S_AXI_ARESETN;
    logic [`AXI_ADDR_W-1:0]     s_axi_awaddr;
    logic                       s_axi_awvalid;
    logic                       s_axi_awready;
    logic [`AXI_DATA_W-1:0]     s_axi_wdata;
    logic [`AXI_DATA_W/8-1:0]   s_axi_wstrb;
    logic                       s_axi_wvalid;
    logic                       s_axi_wready;
    logic [1:0]                 s_axi_bresp;
    logic                       s_axi_bvalid;
    logic                       s_axi_bready;
    logic [`AXI_ADDR_W-1:0]     s_axi_araddr;
    logic                       s_axi_arvalid;
    logic                       s_axi_arready;
    logic [`AXI_DATA_W-1:0]     s_axi_rdata;
    logic [1:0]                 s_axi_rresp;
    logic                       s_axi_rvalid;
    logic                       s_axi_rready;
    logic                       busy;

    stim_t          stim[$];
    logic [31:0]    rng = 32'h23d0;
    int             value_errs = 0;
    int             proto_errs = 0;
    int             cycles = 0;
    int             limit = 1000;

    axi_wb_bridge_top DUT (
        .S_AXI_ACLK      (S_AXI_ACLK),
        .S_AXI_ARESETN   (S_AXI_ARESETN),
        .s_axi_awaddr_i  (s_axi_awaddr),
        .s_axi_awvalid_i (s_axi_awvalid),
        .s_axi_awready_o (s_axi_awready),
        .s_axi_wdata_i   (s_axi_wdata),
        .s_axi_wstrb_i   (s_axi_wstrb),
        .s_axi_wvalid_i  (s_axi_wvalid),
        .s_axi_wready_o  (s_axi_wready),
        .s_axi_bresp_o   (s_axi_bresp),
        .s_axi_bvalid_o  (s_axi_bvalid),
        .s_axi_bready_i  (s_axi_bready),
        .s_axi_araddr_i  (s_axi_araddr),
        .s_axi_arvalid_i (s_axi_arvalid),
        .s_axi_arready_o (s_axi_arready),
        .s_axi_rdata_o   (s_axi_rdata),
        .s_axi_rresp_o   (s_axi_rresp),
        .s_axi_rvalid_o  (s_axi_rvalid),
        .s_axi_rready_i  (s_axi_rready),
        .busy_o          (busy)
    );

    always #2 S_AXI_ACLK = ~S_AXI_ACLK;

    // Run limit, set from the stimulus length once the file is read
    always @(posedge S_AXI_ACLK)
    begin
        cycles++;
        if (cycles >= limit)
        begin
            $display("timeout: no response after %0d cycles", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    // Outputs are stable 1 ns after the edge, inputs change there too
    task automatic next_cycle();
        @(posedge S_AXI_ACLK);
        #1;
    endtask

    task automatic load_stim();
        int    fd;
        int    n;
        string line;
        stim_t s;
        fd = $fopen("verif/axi_wb_stim.txt", "r");
        assert (fd != 0)
        else
        begin
            proto_errs++;
            $display("could not open stimulus file verif/axi_wb_stim.txt");
        end
        while (fd != 0 && !$feof(fd))
        begin
            if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#")
            begin
                n = $sscanf(line, "%c %h %h %h %h %h %h %h", s.op, s.awaddr, s.wdata,
                            s.wstrb, s.araddr, s.rdata, s.bresp, s.rresp);
                if (n == 8)
                    stim.push_back(s);
            end
        end
        if (fd != 0)
            $fclose(fd);
    endtask

    // AW and W stay up until the ready pulse has been seen
    task automatic aw_handshake();
        while (!s_axi_awready)
        begin
            assert (!s_axi_arready)
            else
            begin
                proto_errs++;
                $display("read address accepted while a write was waiting");
            end
            assert (!s_axi_wready)
            else
            begin
                proto_errs++;
                $display("write data accepted without the write address");
            end
            next_cycle();
        end
        // W is taken in the same cycle as AW
        assert (s_axi_wready)
        else
        begin
            proto_errs++;
            $display("write data not accepted together with the write address");
        end
        next_cycle();
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
    endtask

    task automatic ar_handshake();
        while (!s_axi_arready)
            next_cycle();
        next_cycle();
        s_axi_arvalid = 1'b0;
    endtask

    task automatic check_bresp(input logic [`AXI_ADDR_W-1:0] addr, input logic [1:0] exp);
        int hold;
        while (!s_axi_bvalid)
            next_cycle();
        hold = int'(next_rand() % 32'd4);
        repeat (hold) next_cycle();
        assert (s_axi_bresp === exp)
        else
        begin
            value_errs++;
            $display("FAIL t=%0t: write %h bresp %0d, expected %0d",
                     $time, addr, s_axi_bresp, exp);
        end
        s_axi_bready = 1'b1;
        next_cycle();
        s_axi_bready = 1'b0;
        // A second response for the same write would show here
        assert (!s_axi_bvalid)
        else
        begin
            proto_errs++;
            $display("write response still valid after it was taken");
        end
    endtask

    task automatic check_rresp(input logic [`AXI_ADDR_W-1:0] addr,
                               input logic [`AXI_DATA_W-1:0] exp_data,
                               input logic [1:0] exp_resp);
        int hold;
        while (!s_axi_rvalid)
            next_cycle();
        hold = int'(next_rand() % 32'd4);
        repeat (hold) next_cycle();
        assert (s_axi_rresp === exp_resp && s_axi_rdata === exp_data)
        else
        begin
            value_errs++;
            $display("FAIL t=%0t: read %h gave %h resp %0d, expected %h resp %0d",
                     $time, addr, s_axi_rdata, s_axi_rresp, exp_data, exp_resp);
        end
        s_axi_rready = 1'b1;
        next_cycle();
        s_axi_rready = 1'b0;
        assert (!s_axi_rvalid)
        else
        begin
            proto_errs++;
            $display("read response still valid after it was taken");
        end
    endtask

    task automatic issue_write(input stim_t s);
        s_axi_awaddr  = s.awaddr;
        s_axi_wdata   = s.wdata;
        s_axi_wstrb   = s.wstrb;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        aw_handshake();
        check_bresp(s.awaddr, s.bresp);
    endtask

    task automatic issue_read(input stim_t s);
        s_axi_araddr  = s.araddr;
        s_axi_arvalid = 1'b1;
        ar_handshake();
        check_rresp(s.araddr, s.rdata, s.rresp);
    endtask

    // Both channels raised together, the write has to win
    task automatic issue_pair(input stim_t s);
        s_axi_awaddr  = s.awaddr;
        s_axi_wdata   = s.wdata;
        s_axi_wstrb   = s.wstrb;
        s_axi_araddr  = s.araddr;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        s_axi_arvalid = 1'b1;
        aw_handshake();
        check_bresp(s.awaddr, s.bresp);
        ar_handshake();
        check_rresp(s.araddr, s.rdata, s.rresp);
    endtask

    initial
    begin
        stim_t sweep;
        S_AXI_ARESETN = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        load_stim();
        // Register sweep plus every file line, each bounded by the bus timeout
        limit = (stim.size() + `REG_COUNT + 2) * (`WB_TIMEOUT + 12);
        repeat (8) @(posedge S_AXI_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;
        assert (!s_axi_bvalid && !s_axi_rvalid && !busy && !s_axi_awready &&
                !s_axi_wready && !s_axi_arready)
        else
        begin
            value_errs++;
            $display("FAIL t=%0t: outputs not idle after reset", $time);
        end
        // Every register reads back zero with OKAY after reset
        for (int i = 0; i < `REG_COUNT; i++)
        begin
            sweep.araddr = `AXI_ADDR_W'(i * 4);
            sweep.rdata  = '0;
            sweep.rresp  = 2'b00;
            issue_read(sweep);
        end
        foreach (stim[i])
        begin
            if (stim[i].op == "W")
                issue_write(stim[i]);
            else if (stim[i].op == "R")
                issue_read(stim[i]);
            else
                issue_pair(stim[i]);
        end
        repeat (4) next_cycle();
        $display("errors: %0d value, %0d protocol, %0d assertion",
                 value_errs, proto_errs, DUT.u_checker.fail_cnt);
        if (value_errs == 0 && proto_errs == 0 && DUT.u_checker.fail_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* build.f */
+incdir+rtl
rtl/axi_wb_pkg.sv
rtl/axi_lite_slave.sv
rtl/wb_cycle.sv
rtl/wb_reg_file.sv
rtl/axi_wb_bridge_top.sv
verif/axi_wb_checker.sv
verif/tb_axi_wb_bridge.sv

/* verif/axi_wb_stim.txt */
# op awaddr wdata wstrb araddr exp_rdata exp_bresp exp_rresp, all hex
# op W write, R read, B write and read in the same cycle
W 000 000000a5 1 000 00000000 0 0
R 000 00000000 0 000 000000a5 0 0
W 004 12345678 f 000 00000000 0 0
R 000 00000000 0 004 00000078 0 0
W 004 000000ff e 000 00000000 0 0
R 000 00000000 0 004 00000078 0 0
W 03c 0000003c 1 000 00000000 0 0
R 000 00000000 0 03c 0000003c 0 0
W 040 00000011 1 000 00000000 2 0
R 000 00000000 0 040 00000000 0 2
R 000 00000000 0 07c 00000000 0 2
W 080 00000022 1 000 00000000 3 0
R 000 00000000 0 080 00000000 0 3
R 000 00000000 0 3fc 00000000 0 3
B 008 0000005a 1 000 000000a5 0 0
B 00c 000000c3 1 008 0000005a 0 0
R 000 00000000 0 00c 000000c3 0 0
R 000 00000000 0 010 00000000 0 0
W 000 00000000 1 000 00000000 0 0
R 000 00000000 0 000 00000000 0 0
